//--- verilog/duck_pkg.sv
package duck_pkg;

    // game state encoding
    localparam int STATE_W = 2;

    localparam logic [STATE_W-1:0] ST_IDLE  = 2'd0;
    // GAME stays at 2 to match the original game
    localparam logic [STATE_W-1:0] ST_GAME  = 2'd2;
    localparam logic [STATE_W-1:0] ST_SCORE = 2'd3;

    // round time in whole seconds, up to 255
    localparam int TIME_W  = 8;
    localparam int SCORE_W = 8;

    // timing constants
    localparam int MS_PER_S           = 1000;
    localparam int MS_CNT_W           = $clog2(MS_PER_S);
    localparam int CLK_PER_MS_DEFAULT = 75000;

    // APB bus
    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // register map
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h00;
    localparam logic [APB_AW-1:0] ADDR_ROUND  = 8'h04;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h08;
    localparam logic [APB_AW-1:0] ADDR_SCORE  = 8'h0C;

    // CTRL bit positions
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_ABORT_BIT = 1;

    localparam logic [TIME_W-1:0] ROUND_RESET = 8'd10;

endpackage

//--- verilog/duck_regs.sv
`timescale 1ns/1ps

module duck_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [duck_pkg::APB_AW-1:0]         paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [duck_pkg::APB_DW-1:0]         pwdata,
    output logic [duck_pkg::APB_DW-1:0]         prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  logic [duck_pkg::STATE_W-1:0]        state,
    input  logic [duck_pkg::SCORE_W-1:0]        score,
    output logic                                start,
    output logic                                abort,
    output logic [duck_pkg::TIME_W-1:0]         round_time
);

    logic access;
    logic hit_ctrl;
    logic hit_round;
    logic hit_status;
    logic hit_score;
    logic bad_access;
    logic wr_ok;

    // access phase of an APB transfer
    assign access = psel && penable;

    // zero wait states
    assign pready = access;

    // address decode
    assign hit_ctrl   = (paddr == duck_pkg::ADDR_CTRL);
    assign hit_round  = (paddr == duck_pkg::ADDR_ROUND);
    assign hit_status = (paddr == duck_pkg::ADDR_STATUS);
    assign hit_score  = (paddr == duck_pkg::ADDR_SCORE);

    // unmapped address, write to a read-only register, or read of CTRL
    always_comb begin
        bad_access = 1'b0;
        if (!(hit_ctrl || hit_round || hit_status || hit_score)) begin
            bad_access = 1'b1;
        end else if (pwrite && (hit_status || hit_score)) begin
            bad_access = 1'b1;
        end else if (!pwrite && hit_ctrl) begin
            bad_access = 1'b1;
        end
    end

    assign pslverr = access && bad_access;
    assign wr_ok   = access && pwrite && !bad_access;

    // command pulses, high for the single cycle after the CTRL write
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
            abort <= 1'b0;
        end else begin
            start <= wr_ok && hit_ctrl && pwdata[duck_pkg::CTRL_START_BIT];
            abort <= wr_ok && hit_ctrl && pwdata[duck_pkg::CTRL_ABORT_BIT];
        end
    end

    // round time in seconds
    always_ff @(posedge clk) begin
        if (rst) begin
            round_time <= duck_pkg::ROUND_RESET;
        end else if (wr_ok && hit_round) begin
            round_time <= pwdata[duck_pkg::TIME_W-1:0];
        end
    end

    // read data mux, valid in the access phase
    always_comb begin
        prdata = '0;
        if (!pwrite) begin
            if (hit_round) begin
                prdata[duck_pkg::TIME_W-1:0] = round_time;
            end else if (hit_status) begin
                prdata[duck_pkg::STATE_W-1:0] = state;
            end else if (hit_score) begin
                prdata[duck_pkg::SCORE_W-1:0] = score;
            end
        end
    end

endmodule

//--- verilog/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start,
    input  logic                            abort,
    input  logic                            end_of_time,
    output logic [duck_pkg::STATE_W-1:0]    state,
    output logic                            round_over
);

    logic [duck_pkg::STATE_W-1:0] state_nxt;
    logic                         time_up;

    // timer expiry only counts while a round is running
    assign time_up = (state == duck_pkg::ST_GAME) && end_of_time;

    // abort wins over everything else
    always_comb begin
        state_nxt = state;
        if (abort) begin
            state_nxt = duck_pkg::ST_IDLE;
        end else begin
            case (state)
                duck_pkg::ST_IDLE: begin
                    if (start) begin
                        state_nxt = duck_pkg::ST_GAME;
                    end
                end
                duck_pkg::ST_GAME: begin
                    if (end_of_time) begin
                        state_nxt = duck_pkg::ST_SCORE;
                    end
                end
                duck_pkg::ST_SCORE: begin
                    if (start) begin
                        state_nxt = duck_pkg::ST_GAME;
                    end
                end
                default: begin
                    // unused code 1 falls back to idle
                    state_nxt = duck_pkg::ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= duck_pkg::ST_IDLE;
            round_over <= 1'b0;
        end else begin
            state      <= state_nxt;
            // interrupt pulse on the GAME to SCORE edge
            round_over <= time_up && !abort;
        end
    end

endmodule

//--- verilog/game_timer.sv
`timescale 1ns/1ps

module game_timer #(
    parameter int CLK_PER_MS = duck_pkg::CLK_PER_MS_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [duck_pkg::STATE_W-1:0]    state,
    input  logic                            hit,
    input  logic [duck_pkg::TIME_W-1:0]     round_time,
    output logic                            end_of_time
);

    localparam int CLK_W = (CLK_PER_MS > 1) ? $clog2(CLK_PER_MS) : 1;

    logic [CLK_W-1:0]              clk_cnt;
    logic [duck_pkg::MS_CNT_W-1:0] ms_cnt;
    logic [duck_pkg::TIME_W-1:0]   s_cnt;

    logic in_game;
    logic ms_tick;
    logic s_tick;
    logic expired;

    assign in_game = (state == duck_pkg::ST_GAME);

    // prescaler wraps once per millisecond
    assign ms_tick = (clk_cnt == CLK_W'(CLK_PER_MS - 1));

    // last millisecond of a second
    assign s_tick = ms_tick && (ms_cnt == duck_pkg::MS_CNT_W'(duck_pkg::MS_PER_S - 1));

    // full hit-free interval reached, held off while the pulse is still out
    assign expired = (s_cnt == round_time) && !end_of_time;

    always_ff @(posedge clk) begin
        if (rst) begin
            clk_cnt     <= '0;
            ms_cnt      <= '0;
            s_cnt       <= '0;
            end_of_time <= 1'b0;
        end else if (!in_game || hit) begin
            // a hit restarts the interval, leaving GAME parks the timer
            clk_cnt     <= '0;
            ms_cnt      <= '0;
            s_cnt       <= '0;
            end_of_time <= 1'b0;
        end else if (expired) begin
            clk_cnt     <= '0;
            ms_cnt      <= '0;
            s_cnt       <= '0;
            end_of_time <= 1'b1;
        end else begin
            end_of_time <= 1'b0;
            if (ms_tick) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
            if (s_tick) begin
                ms_cnt <= '0;
                s_cnt  <= s_cnt + 1'b1;
            end else if (ms_tick) begin
                ms_cnt <= ms_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/score_counter.sv
`timescale 1ns/1ps

module score_counter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [duck_pkg::STATE_W-1:0]    state,
    input  logic                            hit,
    output logic [duck_pkg::SCORE_W-1:0]    score
);

    logic [duck_pkg::STATE_W-1:0] state_q;
    logic                         in_game;
    logic                         game_entry;

    assign in_game    = (state == duck_pkg::ST_GAME);
    assign game_entry = in_game && (state_q != duck_pkg::ST_GAME);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= duck_pkg::ST_IDLE;
        end else begin
            state_q <= state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            score <= '0;
        end else if (game_entry) begin
            // new round, a hit on the very first cycle still counts
            score <= duck_pkg::SCORE_W'(hit);
        end else if (in_game && hit && (score != '1)) begin
            score <= score + 1'b1;
        end
    end

endmodule

//--- verilog/duck_core.sv
`timescale 1ns/1ps

module duck_core #(
    parameter int CLK_PER_MS = duck_pkg::CLK_PER_MS_DEFAULT
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [duck_pkg::APB_AW-1:0]     paddr,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [duck_pkg::APB_DW-1:0]     pwdata,
    output logic [duck_pkg::APB_DW-1:0]     prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  logic                            hit,
    output logic [duck_pkg::STATE_W-1:0]    state,
    output logic                            round_over
);

    logic                          start;
    logic                          abort;
    logic                          end_of_time;
    logic [duck_pkg::TIME_W-1:0]   round_time;
    logic [duck_pkg::SCORE_W-1:0]  score;

    // CPU side registers
    duck_regs i_regs (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .state      (state),
        .score      (score),
        .start      (start),
        .abort      (abort),
        .round_time (round_time)
    );

    game_fsm i_fsm (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .abort       (abort),
        .end_of_time (end_of_time),
        .state       (state),
        .round_over  (round_over)
    );

    // hit-free interval timer
    game_timer #(
        .CLK_PER_MS (CLK_PER_MS)
    ) i_timer (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .hit         (hit),
        .round_time  (round_time),
        .end_of_time (end_of_time)
    );

    score_counter i_score (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .hit   (hit),
        .score (score)
    );

endmodule

//--- tests/tb_duck_core.sv
`timescale 1ns/1ps

module tb_duck_core;

    // small prescaler so that one second is 2000 cycles
    localparam int CLK_PER_MS_TB = 2;
    localparam int CLK_PER_S     = CLK_PER_MS_TB * duck_pkg::MS_PER_S;
    localparam int APB_TIMEOUT   = 16;
    localparam int EXIT_SLACK    = 20;
    localparam int NUM_HITS      = 5;

    logic                          clk;
    logic                          rst;
    logic [duck_pkg::APB_AW-1:0]   paddr;
    logic                          psel;
    logic                          penable;
    logic                          pwrite;
    logic [duck_pkg::APB_DW-1:0]   pwdata;
    logic [duck_pkg::APB_DW-1:0]   prdata;
    logic                          pready;
    logic                          pslverr;
    logic                          hit;
    logic [duck_pkg::STATE_W-1:0]  state;
    logic                          round_over;

    // reference model of the register contents and game state
    logic [duck_pkg::TIME_W-1:0]   exp_round;
    logic [duck_pkg::SCORE_W-1:0]  exp_score;
    logic [duck_pkg::STATE_W-1:0]  exp_state;

    logic [31:0]                   lcg_state;
    int                            ro_cnt    = 0;
    int                            cycle_cnt = 0;

    duck_core #(
        .CLK_PER_MS (CLK_PER_MS_TB)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .hit        (hit),
        .state      (state),
        .round_over (round_over)
    );

    initial clk = 1'b0;

    always begin
        #10;
        clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // round_over is registered, so the falling edge sees a settled value
    always @(negedge clk) begin
        if (!rst && round_over) begin
            ro_cnt <= ro_cnt + 1;
        end
    end

    task automatic fail_run();
        $display("Regression failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_range(input string name, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi) else begin
            $display("CHECK FAILED at %0d ns: %s is %0d, expected %0d to %0d",
                     $time, name, got, lo, hi);
            fail_run();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // gaps stay well below one second, so every hit restarts the timer
    function automatic int next_gap();
        lcg_state = lcg_next(lcg_state);
        return 40 + int'(lcg_state[30:16] % 15'd1500);
    endfunction

    // pslverr rule taken from the register map
    function automatic logic slverr_model(input logic [duck_pkg::APB_AW-1:0] addr,
                                          input logic wr);
        logic mapped;
        mapped = (addr == duck_pkg::ADDR_CTRL) || (addr == duck_pkg::ADDR_ROUND) ||
                 (addr == duck_pkg::ADDR_STATUS) || (addr == duck_pkg::ADDR_SCORE);
        if (!mapped) begin
            return 1'b1;
        end
        if (wr && (addr == duck_pkg::ADDR_STATUS || addr == duck_pkg::ADDR_SCORE)) begin
            return 1'b1;
        end
        if (!wr && addr == duck_pkg::ADDR_CTRL) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // all tasks start and end 2 ns after a rising edge
    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic apb_access(input logic wr, input logic [duck_pkg::APB_AW-1:0] addr,
                              input logic [duck_pkg::APB_DW-1:0] wdata,
                              output logic [duck_pkg::APB_DW-1:0] rdata, output logic err);
        int waited;
        waited  = 0;
        paddr   = addr;
        pwdata  = wdata;
        pwrite  = wr;
        psel    = 1'b1;
        penable = 1'b0;
        tick(1);
        penable = 1'b1;
        #1;
        while (!pready) begin
            if (waited >= APB_TIMEOUT) begin
                $display("timeout: no pready for address 0x%0h at %0d ns", addr, $time);
                fail_run();
            end
            @(posedge clk);
            #3;
            waited++;
        end
        // zero wait states on this bus
        check_value("pready wait cycles", waited, 0);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [duck_pkg::APB_AW-1:0] addr,
                             input logic [duck_pkg::APB_DW-1:0] data);
        logic [duck_pkg::APB_DW-1:0] rdata;
        logic                        err;
        logic                        exp_err;
        exp_err = slverr_model(addr, 1'b1);
        apb_access(1'b1, addr, data, rdata, err);
        check_value("pslverr", err, exp_err);
        if (!exp_err && addr == duck_pkg::ADDR_ROUND) begin
            exp_round = data[duck_pkg::TIME_W-1:0];
        end
    endtask

    task automatic read_reg(input logic [duck_pkg::APB_AW-1:0] addr);
        logic [duck_pkg::APB_DW-1:0] rdata;
        logic                        err;
        apb_access(1'b0, addr, '0, rdata, err);
        check_value("pslverr", err, slverr_model(addr, 1'b0));
        if (addr == duck_pkg::ADDR_ROUND) begin
            check_value("prdata of ROUND", rdata, 32'(exp_round));
        end else if (addr == duck_pkg::ADDR_STATUS) begin
            check_value("prdata of STATUS", rdata, 32'(exp_state));
        end else if (addr == duck_pkg::ADDR_SCORE) begin
            check_value("prdata of SCORE", rdata, 32'(exp_score));
        end
    endtask

    task automatic wait_state(input logic [duck_pkg::STATE_W-1:0] target, input int max_cycles);
        int cycles;
        cycles = 0;
        while (state !== target) begin
            if (cycles >= max_cycles) begin
                $display("timeout: state did not reach %0d within %0d cycles at %0d ns",
                         target, max_cycles, $time);
                fail_run();
            end
            tick(1);
            cycles++;
        end
        // entering GAME starts a fresh score
        if (target == duck_pkg::ST_GAME && exp_state != duck_pkg::ST_GAME) begin
            exp_score = '0;
        end
        exp_state = target;
    endtask

    task automatic stay_in_game(input int n);
        for (int k = 0; k < n; k++) begin
            tick(1);
            check_value("state", state, duck_pkg::ST_GAME);
        end
    endtask

    task automatic pulse_hit();
        hit = 1'b1;
        tick(1);
        hit = 1'b0;
        if (exp_state == duck_pkg::ST_GAME && exp_score != '1) begin
            exp_score = exp_score + 1'b1;
        end
    endtask

    initial begin : stimulus
        int t0;
        int ro_before;
        int gap;
        rst       = 1'b1;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        hit       = 1'b0;
        lcg_state = 32'hcd25cfec;
        exp_round = duck_pkg::ROUND_RESET;
        exp_score = '0;
        exp_state = duck_pkg::ST_IDLE;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        // reset values and register access
        check_value("round_over", round_over, 1'b0);
        read_reg(duck_pkg::ADDR_STATUS);
        read_reg(duck_pkg::ADDR_SCORE);
        read_reg(duck_pkg::ADDR_ROUND);
        write_reg(duck_pkg::ADDR_ROUND, 32'd37);
        read_reg(duck_pkg::ADDR_ROUND);
        read_reg(8'h10);
        read_reg(duck_pkg::ADDR_CTRL);
        write_reg(duck_pkg::ADDR_STATUS, 32'h2);
        write_reg(duck_pkg::ADDR_SCORE, 32'h55);
        write_reg(8'h1C, 32'hff);
        read_reg(duck_pkg::ADDR_STATUS);
        read_reg(duck_pkg::ADDR_SCORE);
        read_reg(duck_pkg::ADDR_ROUND);
        check_value("state", state, exp_state);

        // a round without hits
        write_reg(duck_pkg::ADDR_ROUND, 32'd2);
        ro_before = ro_cnt;
        write_reg(duck_pkg::ADDR_CTRL, 32'h1);
        wait_state(duck_pkg::ST_GAME, 8);
        t0 = cycle_cnt;
        wait_state(duck_pkg::ST_SCORE, int'(exp_round) * CLK_PER_S + EXIT_SLACK);
        check_range("cycles in GAME", cycle_cnt - t0, int'(exp_round) * CLK_PER_S,
                    int'(exp_round) * CLK_PER_S + EXIT_SLACK);
        tick(4);
        check_value("round_over pulses", ro_cnt - ro_before, 1);
        read_reg(duck_pkg::ADDR_STATUS);
        read_reg(duck_pkg::ADDR_SCORE);

        // hits restart the timer, start from SCORE
        write_reg(duck_pkg::ADDR_ROUND, 32'd1);
        ro_before = ro_cnt;
        write_reg(duck_pkg::ADDR_CTRL, 32'h1);
        wait_state(duck_pkg::ST_GAME, 8);
        for (int i = 0; i < NUM_HITS; i++) begin
            gap = next_gap();
            stay_in_game(gap);
            pulse_hit();
            t0 = cycle_cnt;
            read_reg(duck_pkg::ADDR_SCORE);
        end
        wait_state(duck_pkg::ST_SCORE, int'(exp_round) * CLK_PER_S + EXIT_SLACK);
        check_range("cycles after last hit", cycle_cnt - t0, int'(exp_round) * CLK_PER_S,
                    int'(exp_round) * CLK_PER_S + EXIT_SLACK);
        tick(4);
        check_value("round_over pulses", ro_cnt - ro_before, 1);
        read_reg(duck_pkg::ADDR_SCORE);

        // hits in SCORE and IDLE are ignored
        for (int i = 0; i < 3; i++) begin
            pulse_hit();
            tick(3);
        end
        read_reg(duck_pkg::ADDR_SCORE);
        read_reg(duck_pkg::ADDR_STATUS);
        ro_before = ro_cnt;
        write_reg(duck_pkg::ADDR_CTRL, 32'h2);
        wait_state(duck_pkg::ST_IDLE, 8);
        for (int i = 0; i < 3; i++) begin
            pulse_hit();
            tick(3);
        end
        read_reg(duck_pkg::ADDR_SCORE);
        write_reg(duck_pkg::ADDR_CTRL, 32'h1);
        wait_state(duck_pkg::ST_GAME, 8);
        read_reg(duck_pkg::ADDR_SCORE);

        // abort in the middle of a round
        pulse_hit();
        read_reg(duck_pkg::ADDR_SCORE);
        write_reg(duck_pkg::ADDR_CTRL, 32'h2);
        wait_state(duck_pkg::ST_IDLE, 8);
        tick(4);
        check_value("round_over pulses", ro_cnt - ro_before, 0);
        read_reg(duck_pkg::ADDR_STATUS);

        // zero round time ends the round at once
        write_reg(duck_pkg::ADDR_ROUND, 32'd0);
        read_reg(duck_pkg::ADDR_ROUND);
        write_reg(duck_pkg::ADDR_CTRL, 32'h1);
        wait_state(duck_pkg::ST_GAME, 8);
        wait_state(duck_pkg::ST_SCORE, 4);
        tick(3);
        check_value("round_over pulses", ro_cnt - ro_before, 1);
        read_reg(duck_pkg::ADDR_STATUS);

        // start and abort together, abort wins
        write_reg(duck_pkg::ADDR_CTRL, 32'h3);
        wait_state(duck_pkg::ST_IDLE, 8);
        tick(3);
        check_value("state", state, duck_pkg::ST_IDLE);
        check_value("round_over pulses", ro_cnt - ro_before, 1);

        $display("Regression passed");
        $finish;
    end

endmodule

//--- sim.f
verilog/duck_pkg.sv
verilog/duck_regs.sv
verilog/game_fsm.sv
verilog/game_timer.sv
verilog/score_counter.sv
verilog/duck_core.sv
tests/tb_duck_core.sv

//--- Bender.yml
package:
  name: duck_core

dependencies: {}

sources:
  - files:
      - verilog/duck_pkg.sv
      - verilog/duck_regs.sv
      - verilog/game_fsm.sv
      - verilog/game_timer.sv
      - verilog/score_counter.sv
      - verilog/duck_core.sv
  - target: test
    files:
      - tests/tb_duck_core.sv
